// ==== packet_planner.f ====
source/planner_cfg_pkg.sv
source/planner_types_pkg.sv
source/stream_fifo.sv
source/planner_cfg_regs.sv
source/space_allocator.sv
source/packet_planner_top.sv
bench/packet_planner_tb.sv

// ==== bench/planner_stimulus.txt ====
# c repeat vld0 len0 meta0 vld1 len1 meta1 cfg_we cfg_addr cfg_wdata rd_ptr (all hex)
# e stream meta len gives the per-stream planned order, t name names the following cycles
t order
c 1 1 0a 01 1 14 81 0 0 00 000
c 1 1 03 02 1 1e 82 0 0 00 000
c 1 1 40 03 0 00 00 0 0 00 000
c 1 0 00 00 1 05 83 0 0 00 000
c 4 0 00 00 0 00 00 0 0 00 000
t config
c 1 0 00 00 0 00 00 1 0 00 000
c 1 0 00 00 0 00 00 1 1 00 000
c 1 1 1d 10 1 13 90 0 0 00 000
c 3 0 00 00 0 00 00 0 0 00 000
c 1 0 00 00 0 00 00 1 1 05 000
c 1 1 21 11 1 01 91 0 0 00 000
c 3 0 00 00 0 00 00 0 0 00 000
c 1 0 00 00 0 00 00 1 0 0a 000
c 1 0 00 00 0 00 00 1 1 07 000
c 1 1 16 12 1 17 92 0 0 00 000
c 3 0 00 00 0 00 00 0 0 00 000
t stall
c 1 1 e8 20 1 f1 a0 0 0 00 1a0
c 1 1 f0 21 1 e4 a1 0 0 00 1a0
c 1 1 d8 22 1 d9 a2 0 0 00 1a0
c 1 1 f6 23 1 f5 a3 0 0 00 1a0
c 1 1 e0 24 1 e2 a4 0 0 00 1a0
c 1 1 ea 25 1 ee a5 0 0 00 1a0
c 1 1 f2 26 1 f0 a6 0 0 00 1a0
c 1 1 dc 27 1 df a7 0 0 00 1a0
c 4 0 00 00 0 00 00 0 0 00 1a0
t resume
c 3 0 00 00 0 00 00 0 0 00 3a0
c 3 0 00 00 0 00 00 0 0 00 1a0
c 3 0 00 00 0 00 00 0 0 00 3a0
c 3 0 00 00 0 00 00 0 0 00 1a0
c 3 0 00 00 0 00 00 0 0 00 3a0
c 3 0 00 00 0 00 00 0 0 00 1a0
c 3 0 00 00 0 00 00 0 0 00 3a0
e 0 01 0a
e 0 02 03
e 0 03 40
e 0 10 1d
e 0 11 21
e 0 12 16
e 0 20 e8
e 0 21 f0
e 0 22 d8
e 0 23 f6
e 0 24 e0
e 0 25 ea
e 0 26 f2
e 0 27 dc
e 1 81 14
e 1 82 1e
e 1 83 05
e 1 90 13
e 1 91 01
e 1 92 17
e 1 a0 f1
e 1 a1 e4
e 1 a2 d9
e 1 a3 f5
e 1 a4 e2
e 1 a5 ee
e 1 a6 f0
e 1 a7 df

// ==== bench/packet_planner_tb.sv ====
// Packet planner testbench
// Replays the stimulus file, models the buffer pointers and checks every
// planned lane, the write pointer, the allocator state and almost-full
module packet_planner_tb;
    import planner_cfg_pkg::*;
    import planner_types_pkg::*;

    localparam int    clk_period = 4;
    localparam string stim_file  = "bench/planner_stimulus.txt";

    // Everything driven into the DUT in one cycle
    typedef struct packed {
        logic                  vld_0;
        pkt_desc_t             desc_0;
        logic                  vld_1;
        pkt_desc_t             desc_1;
        logic                  cfg_we;
        cfg_reg_e              cfg_addr;
        logic [7:0]            cfg_wdata;
        logic [addr_width-1:0] rd_ptr;
    } stim_t;

    logic                  clk;
    logic                  rst;
    logic                  rx_vld [stream_count];
    pkt_desc_t             rx_desc [stream_count];
    logic                  rx_afull [stream_count];
    logic                  cfg_we;
    cfg_reg_e              cfg_addr;
    logic [7:0]            cfg_wdata;
    logic [addr_width-1:0] rd_ptr;
    planned_pkt_t          planned [lane_count];
    logic [addr_width-1:0] wr_ptr;
    alloc_state_e          alloc_state;

    stim_t     stim_q [$];
    string     name_q [$];
    pkt_desc_t exp_q0 [$];
    pkt_desc_t exp_q1 [$];

    // Model of the configuration and pointer as the DUT should hold them
    stim_t                 cur;
    planner_cfg_t          model_cfg;
    logic [addr_width-1:0] run_ptr;
    int                    avail [stream_count];
    int checks = 0;
    int pkt_errors = 0;
    int ptr_errors = 0;
    int state_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    packet_planner_top packet_planner_top_i (
        .clk         (clk),
        .rst         (rst),
        .rx_vld      (rx_vld),
        .rx_desc     (rx_desc),
        .rx_afull    (rx_afull),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .rd_ptr      (rd_ptr),
        .planned     (planned),
        .wr_ptr      (wr_ptr),
        .alloc_state (alloc_state)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Length plus gap, rounded up to a whole number of alignment units
    function automatic int space_needed(input int len, input planner_cfg_t c);
        int unit;
        unit = 1 << int'(c.align_log2);
        return ((len + int'(c.gap) + unit - 1) / unit) * unit;
    endfunction

    function automatic planned_pkt_t make_lane(input logic stream, input pkt_desc_t desc,
                                               input logic [addr_width-1:0] addr);
        planned_pkt_t lane;
        lane.vld    = 1'b1;
        lane.stream = stream;
        lane.meta   = desc.meta;
        lane.len    = desc.len;
        lane.addr   = addr;
        return lane;
    endfunction

    function automatic int total_errors();
        return pkt_errors + ptr_errors + state_errors + flag_errors + other_errors;
    endfunction

    // Fields of an idle lane are left unchecked
    task automatic check_pkt(input string name, input planned_pkt_t exp, input planned_pkt_t act);
        checks++;
        if (exp.vld ? (act !== exp) : (act.vld !== 1'b0)) begin
            pkt_errors++;
            $display("[FAIL] %s: expected %0b/%0d/%h/%h/%h, actual %0b/%0d/%h/%h/%h",
                     name, exp.vld, exp.stream, exp.meta, exp.len, exp.addr,
                     act.vld, act.stream, act.meta, act.len, act.addr);
        end
    endtask

    task automatic check_ptr(input string name, input logic [addr_width-1:0] exp,
                             input logic [addr_width-1:0] act);
        checks++;
        if (act !== exp) begin
            ptr_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input alloc_state_e exp, input alloc_state_e act);
        checks++;
        if (act !== exp) begin
            state_errors++;
            $display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            flag_errors++;
            $display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic print_summary();
        $display("Checks %0d, errors %0d (packet %0d, pointer %0d, state %0d, flag %0d, other %0d)",
                 checks, total_errors(), pkt_errors, ptr_errors, state_errors, flag_errors,
                 other_errors);
    endtask

    task automatic drive_inputs();
        rx_vld[0]  = cur.vld_0;
        rx_desc[0] = cur.desc_0;
        rx_vld[1]  = cur.vld_1;
        rx_desc[1] = cur.desc_1;
        cfg_we     = cur.cfg_we;
        cfg_addr   = cur.cfg_addr;
        cfg_wdata  = cur.cfg_wdata;
        rd_ptr     = cur.rd_ptr;
    endtask

    task automatic load_stimulus(output bit ok);
        int        fd;
        int        n;
        int        v [11];
        string     line;
        string     name;
        stim_t     rec;
        pkt_desc_t desc;
        name = "start";
        fd = $fopen(stim_file, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1) begin
                    case (line[0])
                        "t": begin
                            n = $sscanf(line, "t %s", name);
                        end
                        "e": begin
                            n = $sscanf(line, "e %h %h %h", v[0], v[1], v[2]);
                            desc.meta = 8'(v[1]);
                            desc.len  = 8'(v[2]);
                            if (v[0] == 0) exp_q0.push_back(desc);
                            else exp_q1.push_back(desc);
                        end
                        "c": begin
                            n = $sscanf(line, "c %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1],
                                        v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
                            if (n != 11) begin
                                other_errors++;
                                $display("Malformed cycle line in stimulus file: %s", line);
                            end
                            rec.vld_0       = v[1][0];
                            rec.desc_0.len  = 8'(v[2]);
                            rec.desc_0.meta = 8'(v[3]);
                            rec.vld_1       = v[4][0];
                            rec.desc_1.len  = 8'(v[5]);
                            rec.desc_1.meta = 8'(v[6]);
                            rec.cfg_we      = v[7][0];
                            rec.cfg_addr    = cfg_reg_e'(2'(v[8]));
                            rec.cfg_wdata   = 8'(v[9]);
                            rec.rd_ptr      = addr_width'(v[10]);
                            for (int k = 0; k < v[0]; k++) begin
                                stim_q.push_back(rec);
                                name_q.push_back(name);
                            end
                        end
                        default: begin
                            n = 0;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Checks the outputs of the cycle that just ended, then drives the next one
    task automatic step(input stim_t nxt, input string name);
        planned_pkt_t exp_lane [lane_count];
        bit           has_0;
        bit           has_1;
        bit           take_0;
        bit           take_1;
        int           room;
        int           fp_0;
        int           fp_1;
        int           n;
        int           cnt_0;
        int           cnt_1;
        @(posedge clk);
        #1;
        cnt_0 = avail[0];
        cnt_1 = avail[1];
        has_0 = avail[0] > 0 && exp_q0.size() > 0;
        has_1 = avail[1] > 0 && exp_q1.size() > 0;
        // One byte always stays unused between the pointers
        room = (int'(cur.rd_ptr) - int'(run_ptr) - 1 + space_size) % space_size;
        fp_0 = has_0 ? space_needed(int'(exp_q0[0].len), model_cfg) : 0;
        take_0 = has_0 && fp_0 <= room;
        if (take_0) room -= fp_0;
        fp_1 = has_1 ? space_needed(int'(exp_q1[0].len), model_cfg) : 0;
        take_1 = has_1 && fp_1 <= room && (take_0 || !has_0);
        exp_lane[0] = '0;
        exp_lane[1] = '0;
        n = 0;
        if (take_0) begin
            exp_lane[n] = make_lane(1'b0, exp_q0.pop_front(), run_ptr);
            run_ptr = run_ptr + addr_width'(fp_0);
            avail[0]--;
            n++;
        end
        if (take_1) begin
            exp_lane[n] = make_lane(1'b1, exp_q1.pop_front(), run_ptr);
            run_ptr = run_ptr + addr_width'(fp_1);
            avail[1]--;
        end
        for (int i = 0; i < lane_count; i++) begin
            check_pkt($sformatf("%s lane %0d", name, i), exp_lane[i], planned[i]);
        end
        check_ptr({name, " wr_ptr"}, run_ptr, wr_ptr);
        check_state({name, " state"},
                    ((has_0 && !take_0) || (has_1 && !take_1)) ? alloc_full : alloc_run,
                    alloc_state);
        check_flag({name, " afull 0"}, cnt_0 >= fifo_afull_level, rx_afull[0]);
        check_flag({name, " afull 1"}, cnt_1 >= fifo_afull_level, rx_afull[1]);
        // Writes clocked at this edge count from the next cycle on
        if (cur.cfg_we && cur.cfg_addr == cfg_gap) begin
            model_cfg.gap = cur.cfg_wdata[gap_width-1:0];
        end else if (cur.cfg_we && cur.cfg_addr == cfg_align_log2) begin
            model_cfg.align_log2 = (cur.cfg_wdata > 8'd5) ? 3'd5 : cur.cfg_wdata[2:0];
        end
        avail[0] += int'(cur.vld_0);
        avail[1] += int'(cur.vld_1);
        cur = nxt;
        drive_inputs();
    endtask

    initial begin
        bit    ok;
        stim_t idle;
        rst = 1'b1;
        cur = '0;
        drive_inputs();
        model_cfg.gap        = gap_width'(gap_reset);
        model_cfg.align_log2 = align_width'(align_log2_reset);
        run_ptr  = '0;
        avail[0] = 0;
        avail[1] = 0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not open the stimulus file %s", stim_file);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            cycle_limit = stim_q.size() + 200;
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            for (int i = 0; i < stim_q.size(); i++) begin
                step(stim_q[i], name_q[i]);
            end
            idle = cur;
            idle.vld_0  = 1'b0;
            idle.vld_1  = 1'b0;
            idle.cfg_we = 1'b0;
            while (exp_q0.size() > 0 || exp_q1.size() > 0) begin
                step(idle, "drain");
            end
            repeat (2) step(idle, "drain");
            if (avail[0] != 0 || avail[1] != 0) begin
                other_errors++;
                $display("Descriptors were written that the stimulus file never expected");
            end
            print_summary();
            if (total_errors() == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

    // Watchdog against a run that never drains
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        print_summary();
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== source/packet_planner_top.sv ====
// Packet planner top level
// Two stream FIFOs feed the space allocator, which places packets in the
// circular buffer under the gap and alignment held by the configuration block
module packet_planner_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   rx_vld [planner_cfg_pkg::stream_count],
    input  planner_types_pkg::pkt_desc_t           rx_desc [planner_cfg_pkg::stream_count],
    output logic                                   rx_afull [planner_cfg_pkg::stream_count],
    input  logic                                   cfg_we,
    input  planner_cfg_pkg::cfg_reg_e              cfg_addr,
    input  logic [7:0]                             cfg_wdata,
    input  logic [planner_cfg_pkg::addr_width-1:0] rd_ptr,
    output planner_types_pkg::planned_pkt_t        planned [planner_cfg_pkg::lane_count],
    output logic [planner_cfg_pkg::addr_width-1:0] wr_ptr,
    output planner_types_pkg::alloc_state_e        alloc_state
);
    import planner_cfg_pkg::*;
    import planner_types_pkg::*;

    // FIFO heads toward the allocator and pops back
    pkt_desc_t    fifo_head  [stream_count];
    logic         fifo_empty [stream_count];
    logic         fifo_pop   [stream_count];
    planner_cfg_t cfg;

    stream_fifo fifo_0 (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_vld[0]),
        .push_desc (rx_desc[0]),
        .pop       (fifo_pop[0]),
        .head      (fifo_head[0]),
        .empty     (fifo_empty[0]),
        .afull     (rx_afull[0])
    );

    stream_fifo fifo_1 (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_vld[1]),
        .push_desc (rx_desc[1]),
        .pop       (fifo_pop[1]),
        .head      (fifo_head[1]),
        .empty     (fifo_empty[1]),
        .afull     (rx_afull[1])
    );

    planner_cfg_regs cfg_regs_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    space_allocator allocator_i (
        .clk     (clk),
        .rst     (rst),
        .head    (fifo_head),
        .empty   (fifo_empty),
        .cfg     (cfg),
        .rd_ptr  (rd_ptr),
        .pop     (fifo_pop),
        .planned (planned),
        .wr_ptr  (wr_ptr),
        .state   (alloc_state)
    );

endmodule

// ==== source/space_allocator.sv ====
// Space allocator
// Places up to two stream heads per cycle in the circular buffer space,
// registers the planned lanes and advances the write pointer
module space_allocator (
    input  logic                                   clk,
    input  logic                                   rst,
    input  planner_types_pkg::pkt_desc_t           head [planner_cfg_pkg::stream_count],
    input  logic                                   empty [planner_cfg_pkg::stream_count],
    input  planner_types_pkg::planner_cfg_t        cfg,
    input  logic [planner_cfg_pkg::addr_width-1:0] rd_ptr,
    output logic                                   pop [planner_cfg_pkg::stream_count],
    output planner_types_pkg::planned_pkt_t        planned [planner_cfg_pkg::lane_count],
    output logic [planner_cfg_pkg::addr_width-1:0] wr_ptr,
    output planner_types_pkg::alloc_state_e        state
);
    import planner_cfg_pkg::*;
    import planner_types_pkg::*;

    logic [addr_width-1:0] align_mask;
    logic [addr_width-1:0] free_0;
    logic [addr_width-1:0] free_1;
    logic [addr_width-1:0] fp_0;
    logic [addr_width-1:0] fp_1;
    logic [addr_width-1:0] addr_1;
    logic [addr_width-1:0] wr_ptr_next;
    logic                  take_0;
    logic                  take_1;
    logic                  stall;
    planned_pkt_t          cand_0;
    planned_pkt_t          cand_1;
    planned_pkt_t          lane_next [lane_count];

    // Length plus gap, rounded up to the next alignment boundary
    function automatic logic [addr_width-1:0] footprint(
        input logic [len_width-1:0]  len,
        input logic [gap_width-1:0]  gap,
        input logic [addr_width-1:0] mask
    );
        logic [addr_width-1:0] raw;
        raw = addr_width'(len) + addr_width'(gap) + mask;
        return raw & ~mask;
    endfunction

    assign align_mask = (addr_width'(1) << cfg.align_log2) - addr_width'(1);

    always_comb begin
        // One byte stays unused so a full space never looks empty
        free_0 = rd_ptr - wr_ptr - addr_width'(1);
        fp_0   = footprint(head[0].len, cfg.gap, align_mask);
        take_0 = !empty[0] && (fp_0 <= free_0);

        // Stream 1 is tried against the space left after stream 0
        free_1 = take_0 ? (free_0 - fp_0) : free_0;
        addr_1 = take_0 ? (wr_ptr + fp_0) : wr_ptr;
        fp_1   = footprint(head[1].len, cfg.gap, align_mask);

        // A stalled stream 0 holds stream 1 back as well
        take_1 = !empty[1] && (fp_1 <= free_1) && (take_0 || empty[0]);

        stall       = (!empty[0] && !take_0) || (!empty[1] && !take_1);
        wr_ptr_next = take_1 ? (addr_1 + fp_1) : addr_1;

        cand_0.vld    = take_0;
        cand_0.stream = 1'b0;
        cand_0.meta   = head[0].meta;
        cand_0.len    = head[0].len;
        cand_0.addr   = wr_ptr;

        cand_1.vld    = take_1;
        cand_1.stream = 1'b1;
        cand_1.meta   = head[1].meta;
        cand_1.len    = head[1].len;
        cand_1.addr   = addr_1;

        // Lane 0 carries the first placement of the cycle
        if (take_0) begin
            lane_next[0] = cand_0;
            lane_next[1] = cand_1;
        end else begin
            lane_next[0] = cand_1;
            lane_next[1] = '0;
        end
    end

    assign pop[0] = take_0;
    assign pop[1] = take_1;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            state  <= alloc_run;
            for (int i = 0; i < lane_count; i++) begin
                planned[i].vld <= 1'b0;
            end
        end else begin
            wr_ptr <= wr_ptr_next;
            state  <= stall ? alloc_full : alloc_run;
            for (int i = 0; i < lane_count; i++) begin
                planned[i] <= lane_next[i];
            end
        end
    end

    // Planned addresses sit on the alignment in force when they were placed
    assert property (@(posedge clk) disable iff (rst)
        planned[0].vld |-> ((planned[0].addr & $past(align_mask)) == '0) &&
                           (!planned[1].vld || ((planned[1].addr & $past(align_mask)) == '0)))
        else $error("space_allocator: planned address not aligned");

    // Lane 1 only ever holds the second packet of a cycle
    assert property (@(posedge clk) disable iff (rst)
        planned[1].vld |-> planned[0].vld && (planned[1].stream != planned[0].stream))
        else $error("space_allocator: lane 1 valid without lane 0");

    // The pointer never moves by more than the space the consumer left free
    assert property (@(posedge clk) disable iff (rst)
        take_0 || take_1 |=> (wr_ptr - $past(wr_ptr)) <= $past(free_0))
        else $error("space_allocator: write pointer passed the read pointer");

endmodule

// ==== source/planner_cfg_regs.sv ====
// Planner configuration registers
// Gap size and address alignment, loaded by single-cycle write strobes
module planner_cfg_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_we,
    input  planner_cfg_pkg::cfg_reg_e       cfg_addr,
    input  logic [7:0]                      cfg_wdata,
    output planner_types_pkg::planner_cfg_t cfg
);
    import planner_cfg_pkg::*;

    logic [align_width-1:0] align_wdata;

    // Alignment above 32 bytes is clamped to 32
    assign align_wdata = (cfg_wdata > 8'(align_log2_max)) ?
                         align_width'(align_log2_max) :
                         cfg_wdata[align_width-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.gap        <= gap_width'(gap_reset);
            cfg.align_log2 <= align_width'(align_log2_reset);
        end else if (cfg_we) begin
            case (cfg_addr)
                cfg_gap: begin
                    cfg.gap <= cfg_wdata[gap_width-1:0];
                end
                cfg_align_log2: begin
                    cfg.align_log2 <= align_wdata;
                end
                default: begin
                    cfg.gap <= cfg.gap;
                end
            endcase
        end
    end

    // The allocator builds its mask from this field, so it must stay in range
    assert property (@(posedge clk) disable iff (rst)
        cfg.align_log2 <= align_width'(align_log2_max))
        else $error("planner_cfg_regs: alignment out of range");

endmodule

// ==== source/stream_fifo.sv ====
// Per-stream descriptor FIFO
// Holds descriptors until the allocator places them and warns the source
// through a registered almost-full level
module stream_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  planner_types_pkg::pkt_desc_t push_desc,
    input  logic                         pop,
    output planner_types_pkg::pkt_desc_t head,
    output logic                         empty,
    output logic                         afull
);
    import planner_cfg_pkg::*;
    import planner_types_pkg::*;

    pkt_desc_t                   mem [fifo_depth];
    logic [fifo_ptr_width-1:0]   wr_idx;
    logic [fifo_ptr_width-1:0]   rd_idx;
    logic [fifo_count_width-1:0] count;
    logic                        full;

    assign empty = (count == '0);
    assign full  = (count == fifo_count_width'(fifo_depth));

    // The head is read straight from the store
    assign head = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= push_desc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
            afull  <= 1'b0;
        end else begin
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
            // Rises one cycle after the count reaches the level
            afull <= (count >= fifo_count_width'(fifo_afull_level));
        end
    end

    // The source has to honour afull before the store runs out
    assert property (@(posedge clk) disable iff (rst)
        push && full |-> pop)
        else $error("stream_fifo: descriptor written into a full FIFO");

    // The allocator only pops a head that it has seen
    assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("stream_fifo: pop from an empty FIFO");

endmodule

// ==== source/planner_types_pkg.sv ====
// Packet planner data types
// Descriptors, planned output lanes, configuration and allocator state
package planner_types_pkg;

    // Input descriptor as delivered by a stream and held in its FIFO
    typedef struct packed {
        logic [planner_cfg_pkg::len_width-1:0]  len;
        logic [planner_cfg_pkg::meta_width-1:0] meta;
    } pkt_desc_t;

    // One planned output lane
    // The stream index tells which input the packet came from
    typedef struct packed {
        logic                                   vld;
        logic                                   stream;
        logic [planner_cfg_pkg::meta_width-1:0] meta;
        logic [planner_cfg_pkg::len_width-1:0]  len;
        logic [planner_cfg_pkg::addr_width-1:0] addr;
    } planned_pkt_t;

    // Live configuration seen by the allocator
    typedef struct packed {
        logic [planner_cfg_pkg::gap_width-1:0]   gap;
        logic [planner_cfg_pkg::align_width-1:0] align_log2;
    } planner_cfg_t;

    // Full means a waiting head did not fit in the last cycle
    typedef enum logic {
        alloc_run  = 1'b0,
        alloc_full = 1'b1
    } alloc_state_e;

endpackage

// ==== source/planner_cfg_pkg.sv ====
// Packet planner geometry and configuration register map
// Sizes the buffer space, the descriptor fields and the stream FIFOs
package planner_cfg_pkg;

    // Circular buffer space, a power of two so addresses wrap on their own
    localparam int space_size = 1024;
    localparam int addr_width = $clog2(space_size);

    // Descriptor fields
    localparam int len_width  = 8;
    localparam int meta_width = 8;

    // Two input streams and two planned lanes per cycle
    localparam int stream_count = 2;
    localparam int lane_count   = 2;

    // Per-stream descriptor FIFO
    localparam int fifo_depth       = 8;
    localparam int fifo_ptr_width   = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);
    localparam int fifo_afull_level = 6;

    // Configuration fields and their values after reset
    localparam int gap_width        = 6;
    localparam int align_width      = 3;
    localparam int align_log2_max   = 5;
    localparam int gap_reset        = 4;
    localparam int align_log2_reset = 3;

    // Configuration register addresses
    typedef enum logic [1:0] {
        cfg_gap        = 2'd0,
        cfg_align_log2 = 2'd1
    } cfg_reg_e;

endpackage
